/* sim.f */
+incdir+logic
logic/memPipePkg.sv
logic/dataRam.sv
logic/memStage.sv
logic/mem2Stage.sv
logic/wbStage.sv
logic/memPipeTop.sv
dv/memPipe_chk.sv
dv/clkGen.sv
dv/memPipeTb.sv

/* dv/memPipe_stim.txt */
# aluOut pc outB wbSel dst rfWr ld st stall flush | expWe expData | fwdChk fwdValid fwdResult
# wbSel pc8=0 alu=1 outB=2 mem=3, ld lb=1 lbu=2 lh=3 lhu=4 lw=5, st sb=1 sh=2 sw=3
12345678 00400000 00000000 1 03 1 0 0 0 0 1 12345678 1 1 12345678
00000000 00400010 00000000 0 1f 1 0 0 0 0 1 00400018 1 1 00400018
00000000 00400014 cafef00d 2 05 1 0 0 0 0 1 cafef00d 1 1 cafef00d
deadbeef 00400018 00000000 1 00 1 0 0 0 0 0 00000000 1 1 deadbeef
00000040 00400000 a1b2c3d4 1 00 0 0 3 0 0 0 00000000 0 0 00000000
00000040 00400000 00000000 3 06 1 5 0 0 0 1 a1b2c3d4 0 0 00000000
00000041 00400000 00000000 3 07 1 1 0 0 0 1 ffffffc3 0 0 00000000
00000043 00400000 00000000 3 08 1 2 0 0 0 1 000000a1 0 0 00000000
00000042 00400000 00000000 3 09 1 3 0 0 0 1 ffffa1b2 0 0 00000000
00000040 00400000 00000000 3 0a 1 4 0 0 0 1 0000c3d4 0 0 00000000
00000040 00400000 00000000 3 0b 1 1 0 0 0 1 ffffffd4 0 0 00000000
00000042 00400000 00000000 3 0c 1 1 0 0 0 1 ffffffb2 0 0 00000000
00000044 00400000 00000080 1 00 0 0 1 0 0 0 00000000 0 0 00000000
00000046 00400000 00007ffe 1 00 0 0 2 0 0 0 00000000 0 0 00000000
00000044 00400000 00000000 3 0d 1 1 0 0 0 1 ffffff80 0 0 00000000
00000046 00400000 00000000 3 0e 1 3 0 0 0 1 00007ffe 0 0 00000000
00000048 00400000 11111111 1 00 0 0 3 0 0 0 00000000 0 0 00000000
00000048 00400000 99999999 1 00 0 0 3 0 1 0 00000000 0 0 00000000
00000123 00400000 00000000 1 0f 1 0 0 0 1 0 00000000 1 0 00000000
00000048 00400000 00000000 3 10 1 5 0 0 0 1 11111111 0 0 00000000
00000777 00400000 00000000 1 11 1 0 0 0 0 1 00000777 1 1 00000777
00000040 00400000 00000000 3 12 1 5 0 0 0 1 a1b2c3d4 0 0 00000000
00000000 00000000 00000000 0 00 0 0 0 0 0 0 00000000 0 0 00000000
00000000 00000000 00000000 0 00 0 0 0 1 0 0 00000000 0 0 00000000
00000000 00000000 00000000 0 00 0 0 0 1 0 0 00000000 0 0 00000000
00000888 00400000 00000000 1 13 1 0 0 0 0 1 00000888 1 1 00000888

/* dv/memPipeTb.sv */
module memPipeTb import memPipePkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic     clk;
    logic     rstN;
    logic     stall;
    logic     mem2Flush;
    exMemBusT exIn;
    fwdT      fwd;
    rfWriteT  rfWrite;

    exMemBusT exArr[$];
    logic     stallArr[$];
    logic     flushArr[$];
    logic     fcArr[$];
    fwdT      expFwdArr[$];
    rfWriteT  expWrQ[$];

    logic     pendFlush;
    logic     fcPipe[3];    // fwd checks in flight, index 2 is due
    fwdT      fwdPipe[3];
    int       errFwd;
    int       errWr;
    int       errOther;

    clkGen u_clkGen (.clk(clk), .rstN(rstN));

    memPipeTop u_memPipeTop (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .mem2Flush (mem2Flush),
        .exIn      (exIn),
        .fwd       (fwd),
        .rfWrite   (rfWrite)
    );

    task automatic checkFwd(input fwdT got, input fwdT exp);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.dst !== exp.dst || got.result !== exp.result))) begin
            errFwd++;
            $display("** Error at %0t: fwd got v=%b dst=%0d res=%h, expected v=%b dst=%0d res=%h",
                     $time, got.valid, got.dst, got.result, exp.valid, exp.dst, exp.result);
        end
    endtask

    task automatic checkWrite(input rfWriteT got, input rfWriteT exp);
        if (got.dst !== exp.dst || got.data !== exp.data) begin
            errWr++;
            $display("** Error at %0t: rfWrite got dst=%0d data=%h, expected dst=%0d data=%h",
                     $time, got.dst, got.data, exp.dst, exp.data);
        end
    endtask

    // one clock of stimulus, flush goes out one cycle after its instr
    task driveCycle(input exMemBusT e, input logic st, input logic fl,
                    input logic fc, input fwdT ef);
        @(posedge clk);
        exIn      <= e;
        stall     <= st;
        mem2Flush <= pendFlush;
        pendFlush  = fl;
        fcPipe[2]  = fcPipe[1];
        fwdPipe[2] = fwdPipe[1];
        fcPipe[1]  = fcPipe[0];
        fwdPipe[1] = fwdPipe[0];
        fcPipe[0]  = fc;
        fwdPipe[0] = ef;
        @(negedge clk);
        if (fcPipe[2]) begin
            checkFwd(fwd, fwdPipe[2]);
        end
    endtask

    // every write-back is matched in order against the queue
    always @(negedge clk) begin
        if (rstN && rfWrite.we) begin
            if (expWrQ.size() == 0) begin
                errOther++;
                $display("unexpected register write to r%0d at %0t", rfWrite.dst, $time);
            end else begin
                checkWrite(rfWrite, expWrQ.pop_front());
            end
        end
    end

    initial begin
        int          fd;
        int          n;
        int          ws, d, rw, lt, stt, sl, fl, ew, fc, fv, wait_;
        logic [31:0] a, p, b, ed, fr;
        string       line;
        exMemBusT    e;
        fwdT         ef;
        rfWriteT     wr;

        exIn      = '0;
        stall     = 1'b0;
        mem2Flush = 1'b0;
        pendFlush = 1'b0;
        fcPipe    = '{default: 1'b0};
        fwdPipe   = '{default: '0};
        errFwd    = 0;
        errWr     = 0;
        errOther  = 0;
        void'($urandom(32'h3670));

        fd = $fopen("dv/memPipe_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file dv/memPipe_stim.txt");
            $display("Regression failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                a, p, b, ws, d, rw, lt, stt, sl, fl, ew, ed, fc, fv, fr);
                    if (n == 15) begin
                        e.aluOut    = a;
                        e.pc        = p;
                        e.outB      = b;
                        e.wbSel     = wbSelT'(ws[1:0]);
                        e.dst       = d[4:0];
                        e.rfWr      = rw[0];
                        e.loadType  = loadTypeT'(lt[2:0]);
                        e.storeType = storeTypeT'(stt[1:0]);
                        ef.valid    = fv[0];
                        ef.dst      = d[4:0];
                        ef.result   = fr;
                        exArr.push_back(e);
                        stallArr.push_back(sl[0]);
                        flushArr.push_back(fl[0]);
                        fcArr.push_back(fc[0]);
                        expFwdArr.push_back(ef);
                        if (ew[0]) begin
                            wr.we   = 1'b1;
                            wr.dst  = d[4:0];
                            wr.data = ed;
                            expWrQ.push_back(wr);
                        end
                    end
                end
            end
            $fclose(fd);

            wait_ = 0;
            while (rstN !== 1'b1 && wait_ < 20) begin
                @(posedge clk);
                wait_++;
            end
            if (rstN !== 1'b1) begin
                errOther++;
                $display("reset never released");
            end

            for (int i = 0; i < exArr.size(); i++) begin
                driveCycle(exArr[i], stallArr[i], flushArr[i], fcArr[i], expFwdArr[i]);
                n = $urandom_range(2, 0);
                // a stall row acts on the instr two rows back, keep that window tight
                if ((i + 1 < exArr.size() && stallArr[i + 1]) ||
                    (i + 2 < exArr.size() && stallArr[i + 2])) begin
                    n = 0;
                end
                repeat (n) driveCycle('0, 1'b0, 1'b0, 1'b0, '0); // idle gap
            end
            repeat (3) driveCycle('0, 1'b0, 1'b0, 1'b0, '0);

            wait_ = 0;
            while (expWrQ.size() != 0 && wait_ < 50) begin
                @(posedge clk);
                wait_++;
            end
            if (expWrQ.size() != 0) begin
                errOther++;
                $display("timed out with %0d write-backs still missing", expWrQ.size());
            end
            repeat (4) @(posedge clk); // catch stray writes

            $display("errors: fwd %0d, write %0d, other %0d", errFwd, errWr, errOther);
            if (errFwd + errWr + errOther == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

/* dv/clkGen.sv */
module clkGen (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

/* dv/memPipe_chk.sv */
module memPipe_chk import memPipePkg::*; (
    input logic    clk,
    input logic    rstN,
    input logic    stall,
    input logic    mem2Flush,
    input fwdT     fwd,
    input rfWriteT rfWrite
);
    timeunit 1ns;
    timeprecision 100ps;

    // pipeline holds bubbles in and right after reset
    inReset: assert property (@(posedge clk) !rstN |-> !rfWrite.we && !fwd.valid)
        else $error("write or forward active during reset");

    afterReset: assert property (@(posedge clk) $rose(rstN) |-> !rfWrite.we && !fwd.valid)
        else $error("write or forward active after reset release");

    // WB takes a bubble for every stalled edge
    stallBubble: assert property (@(posedge clk) disable iff (!rstN) stall |=> !rfWrite.we)
        else $error("register write one cycle after a stalled edge");

    // flushed instr leaves a bubble in MEM2, then in WB
    flushBubble: assert property (@(posedge clk) disable iff (!rstN)
        mem2Flush && !stall |=> !fwd.valid ##1 !rfWrite.we)
        else $error("flushed instruction reached forward or write-back");

endmodule

bind memPipeTop memPipe_chk u_chk (
    .clk       (clk),
    .rstN      (rstN),
    .stall     (stall),
    .mem2Flush (mem2Flush),
    .fwd       (fwd),
    .rfWrite   (rfWrite)
);

/* logic/memPipeTop.sv */
`include "memPipe_defs.svh"

module memPipeTop import memPipePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     stall,
    input  logic     mem2Flush,
    input  exMemBusT exIn,
    output fwdT      fwd,
    output rfWriteT  rfWrite
);

    mem2BusT            memOut;
    dbusReqT            dbusReq;
    logic [`DATA_W-1:0] rdata;
    mem2BusT            wbIn;
    logic [`DATA_W-1:0] wbLoadData;
    logic               wbValid;

    memStage u_memStage (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .mem2Flush (mem2Flush),
        .exIn      (exIn),
        .memOut    (memOut),
        .dbusReq   (dbusReq)
    );

    // answers one edge after the request
    dataRam u_dataRam (
        .clk   (clk),
        .req   (dbusReq),
        .rdata (rdata)
    );

    mem2Stage u_mem2Stage (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .mem2Flush  (mem2Flush),
        .memIn      (memOut),
        .rdata      (rdata),
        .fwd        (fwd),
        .wbIn       (wbIn),
        .wbLoadData (wbLoadData),
        .wbValid    (wbValid)
    );

    wbStage u_wbStage (
        .clk        (clk),
        .rstN       (rstN),
        .wbIn       (wbIn),
        .wbLoadData (wbLoadData),
        .wbValid    (wbValid),
        .rfWrite    (rfWrite)
    );

endmodule

/* logic/wbStage.sv */
`include "memPipe_defs.svh"

module wbStage import memPipePkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  mem2BusT            wbIn,
    input  logic [`DATA_W-1:0] wbLoadData,
    input  logic               wbValid,
    output rfWriteT            rfWrite
);

    mem2BusT            wbQ;
    logic               wbQValid;
    logic [`DATA_W-1:0] loadQ;
    logic [7:0]         loadByte;
    logic [15:0]        loadHalf;
    logic [`DATA_W-1:0] loadExt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbQ      <= '0;
            wbQValid <= 1'b0;
        end else begin
            wbQ      <= wbIn;
            wbQValid <= wbValid;
        end
    end

    always_ff @(posedge clk) begin
        loadQ <= wbLoadData; // raw RAM word
    end

    // lane pick by the low address bits
    assign loadByte = loadQ[8*wbQ.aluOut[1:0] +: 8];
    assign loadHalf = wbQ.aluOut[1] ? loadQ[31:16] : loadQ[15:0];

    always_comb begin
        case (wbQ.loadType)
            ldLb:    loadExt = {{24{loadByte[7]}}, loadByte};
            ldLbu:   loadExt = {24'b0, loadByte};
            ldLh:    loadExt = {{16{loadHalf[15]}}, loadHalf};
            ldLhu:   loadExt = {16'b0, loadHalf};
            default: loadExt = loadQ; // lw
        endcase
    end

    // $zero is never written
    assign rfWrite.we   = wbQValid & wbQ.rfWr & (wbQ.dst != '0);
    assign rfWrite.dst  = wbQ.dst;
    assign rfWrite.data = (wbQ.wbSel == wbMem) ? loadExt : selResult(wbQ);

endmodule

/* logic/mem2Stage.sv */
`include "memPipe_defs.svh"

module mem2Stage import memPipePkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               mem2Flush,
    input  mem2BusT            memIn,
    input  logic [`DATA_W-1:0] rdata,
    output fwdT                fwd,
    output mem2BusT            wbIn,
    output logic [`DATA_W-1:0] wbLoadData,
    output logic               wbValid
);

    mem2BusT            mem2Q;
    logic [`DATA_W-1:0] fwdResult;

    // MEM2 register
    // nothing enters while stalled, so the flush only acts on a moving pipe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mem2Q <= '0;
        end else if (!stall) begin
            if (mem2Flush) begin
                mem2Q <= '0; // bubble in place of the incoming instr
            end else begin
                mem2Q <= memIn;
            end
        end
    end

    // bypass value: pc+8, alu result or operand b
    // a load still here has no result yet, that leg is don't-care
    assign fwdResult = selResult(mem2Q);

    assign fwd.valid  = mem2Q.rfWr; // bubbles carry rfWr low
    assign fwd.dst    = mem2Q.dst;
    assign fwd.result = fwdResult;

    // handoff to WB, RAM data goes straight through
    assign wbIn       = mem2Q;
    assign wbLoadData = rdata;
    assign wbValid    = mem2Q.rfWr & ~stall; // WB takes a bubble while stalled

endmodule

/* logic/memStage.sv */
`include "memPipe_defs.svh"

module memStage import memPipePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     stall,
    input  logic     mem2Flush,
    input  exMemBusT exIn,
    output mem2BusT  memOut,
    output dbusReqT  dbusReq
);

    exMemBusT           memQ;
    logic               isLoad;
    logic               isStore;
    logic [3:0]         storeWen;
    logic [`DATA_W-1:0] storeData;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memQ <= '0; // bubble
        end else if (!stall) begin
            memQ <= exIn;
        end
    end

    assign isLoad  = (memQ.loadType != ldNone);
    assign isStore = (memQ.storeType != stNone);

    // little-endian lane placement, data replicated so any lane sees it
    always_comb begin
        storeData = memQ.outB;
        storeWen  = 4'b0000;
        case (memQ.storeType)
            stSb: begin
                storeData = {4{memQ.outB[7:0]}};
                storeWen  = 4'b0001 << memQ.aluOut[1:0];
            end
            stSh: begin
                storeData = {2{memQ.outB[15:0]}};
                storeWen  = memQ.aluOut[1] ? 4'b1100 : 4'b0011;
            end
            stSw: storeWen = 4'b1111;
            default: ;
        endcase
    end

    assign dbusReq.en    = (isLoad | isStore) & ~stall;
    assign dbusReq.wen   = mem2Flush ? 4'b0000 : storeWen; // flushed store never lands
    assign dbusReq.addr  = memQ.aluOut;
    assign dbusReq.wdata = storeData;

    // everything but the store type moves on
    assign memOut.aluOut   = memQ.aluOut;
    assign memOut.pc       = memQ.pc;
    assign memOut.outB     = memQ.outB;
    assign memOut.wbSel    = memQ.wbSel;
    assign memOut.dst      = memQ.dst;
    assign memOut.rfWr     = memQ.rfWr;
    assign memOut.loadType = memQ.loadType;

endmodule

/* logic/dataRam.sv */
`include "memPipe_defs.svh"

module dataRam import memPipePkg::*; (
    input  logic               clk,
    input  dbusReqT            req,
    output logic [`DATA_W-1:0] rdata
);

    logic [`DATA_W-1:0] mem [2**`RAM_AW];
    logic [`RAM_AW-1:0] wordAddr;

    // byte address to word index, low two bits pick the lane
    assign wordAddr = req.addr[`RAM_AW+1:2];

    // one access per enabled edge, write when any lane is set
    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.wen != 4'b0000) begin
                for (int i = 0; i < 4; i++) begin
                    if (req.wen[i]) begin
                        mem[wordAddr][8*i +: 8] <= req.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[wordAddr]; // held while en is low
            end
        end
    end

endmodule

/* logic/memPipePkg.sv */
`include "memPipe_defs.svh"

package memPipePkg;

    // write-back source, same leg order as the MEM2 result mux
    typedef enum logic [1:0] {
        wbPc8  = 2'd0, // jal/jalr link address
        wbAlu  = 2'd1,
        wbOutB = 2'd2, // operand b passed through
        wbMem  = 2'd3
    } wbSelT;

    typedef enum logic [2:0] {
        ldNone = 3'd0,
        ldLb   = 3'd1,
        ldLbu  = 3'd2,
        ldLh   = 3'd3,
        ldLhu  = 3'd4,
        ldLw   = 3'd5
    } loadTypeT;

    typedef enum logic [1:0] {
        stNone = 2'd0,
        stSb   = 2'd1,
        stSh   = 2'd2,
        stSw   = 2'd3
    } storeTypeT;

    // bundle handed over by execute
    typedef struct packed {
        logic [`DATA_W-1:0] aluOut;    // also the data address
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] outB;
        wbSelT              wbSel;
        logic [`REG_AW-1:0] dst;
        logic               rfWr;
        loadTypeT           loadType;
        storeTypeT          storeType;
    } exMemBusT;

    // MEM and MEM2 register content, store type already consumed
    typedef struct packed {
        logic [`DATA_W-1:0] aluOut;
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] outB;
        wbSelT              wbSel;
        logic [`REG_AW-1:0] dst;
        logic               rfWr;
        loadTypeT           loadType;
    } mem2BusT;

    typedef struct packed {
        logic               en;
        logic [3:0]         wen;   // byte lanes, zero means read
        logic [`DATA_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
    } dbusReqT;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] dst;
        logic [`DATA_W-1:0] data;
    } rfWriteT;

    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] dst;
        logic [`DATA_W-1:0] result;
    } fwdT;

    // non-memory result pick, shared by the MEM2 bypass and WB
    function automatic logic [`DATA_W-1:0] selResult(input mem2BusT bus);
        logic [`DATA_W-1:0] res;
        case (bus.wbSel)
            wbPc8:   res = bus.pc + `DATA_W'd8;
            wbAlu:   res = bus.aluOut;
            wbOutB:  res = bus.outB;
            default: res = 'x; // load data not known here
        endcase
        return res;
    endfunction

endpackage

/* logic/memPipe_defs.svh */
`ifndef MEMPIPE_DEFS_SVH
`define MEMPIPE_DEFS_SVH

// datapath and byte-address width, fixed by the ISA
`define DATA_W 32

// gpr index width
`define REG_AW 5

// word-address bits of the data RAM, 256 words
`define RAM_AW 8

`endif
